//--- project.f
tilemap_pkg.sv
line_setup.sv
tile_fetcher.sv
pixel_queue.sv
line_writer.sv
tilemap_engine.sv
tilemap_asserts.sv
tilemap_tb.sv

//--- Bender.yml
package:
  name: tilemap_engine

sources:
  - tilemap_pkg.sv
  - line_setup.sv
  - tile_fetcher.sv
  - pixel_queue.sv
  - line_writer.sv
  - tilemap_engine.sv
  - target: test
    files:
      - tilemap_asserts.sv
      - tilemap_tb.sv

//--- tilemap_tb.sv
`timescale 1ns/1ps

module tilemap_tb;
    import tilemap_pkg::*;

    typedef struct packed {
        line_cfg_t   cfg;
        logic [15:0] stop_at;   // cycles from start to stop (0 means none)
    } line_row_t;

    logic               clk;
    logic               rst;
    line_cfg_t          cfg;
    logic               start;
    logic               stop;
    logic [VRAM_AW-1:0] vram_addr;
    logic               vram_cs;
    logic [15:0]        vram_data = 16'd0;
    logic               vram_ok = 1'b0;
    logic [ROM_AW-1:0]  rom_addr;
    logic               rom_half;
    logic               rom_cs;
    logic [31:0]        rom_data = 32'd0;
    logic               rom_ok = 1'b0;
    buf_wr_t            line_buf;
    logic               buf_wr;
    logic               done;

    logic [15:0] vram_mem [1024];
    logic [31:0] rom_mem [1024];
    logic [15:0] lfsr;
    logic [1:0]  vram_wait = 2'd0;
    logic [1:0]  rom_wait = 2'd0;
    logic [11:0] shadow [512];     // bit 11 marks a written entry
    int          write_cnt = 0;
    int          done_cnt = 0;
    line_row_t   rows [$];

    tilemap_engine u_dut (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .start    (start),
        .stop     (stop),
        .vram_addr(vram_addr),
        .vram_cs  (vram_cs),
        .vram_data(vram_data),
        .vram_ok  (vram_ok),
        .rom_addr (rom_addr),
        .rom_half (rom_half),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .line_buf (line_buf),
        .buf_wr   (buf_wr),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // random source and memory models

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16,14,13,11
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // high address bits folded into the data so bank bits reach the pixels
    function automatic logic [15:0] vram_word(input logic [16:0] a);
        return vram_mem[a[9:0]] ^ {a[16:10], 9'd0};
    endfunction

    function automatic logic [31:0] rom_word(input logic [19:0] a, input logic half);
        return rom_mem[{a[8:0], half}] ^ {a[19:9], 21'd0};
    endfunction

    initial begin : fill_memories
        logic [31:0] v;
        lfsr = 16'd87;
        for (int a = 0; a < 1024; a++) begin
            take_bits(16, v);
            vram_mem[a] = v[15:0];
            take_bits(32, v);
            rom_mem[a] = v;
        end
    end

    // both models in one block so the draw order is fixed
    always @(posedge clk) begin : mem_models
        logic [31:0] draw;
        vram_ok <= 1'b0;
        rom_ok  <= 1'b0;
        if (vram_cs && !vram_ok) begin
            if (vram_wait == 2'd0) begin
                vram_ok   <= 1'b1;
                vram_data <= vram_word(vram_addr);
                take_bits(2, draw);
                vram_wait <= draw[1:0];   // 1 to 4 cycles next time
            end else begin
                vram_wait <= vram_wait - 2'd1;
            end
        end
        if (rom_cs && !rom_ok) begin
            if (rom_wait == 2'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr, rom_half);
                take_bits(2, draw);
                rom_wait <= draw[1:0];
            end else begin
                rom_wait <= rom_wait - 2'd1;
            end
        end
    end

    // line buffer shadow that each start clears
    always @(posedge clk) begin
        if (start) begin
            for (int x = 0; x < 512; x++) shadow[x] <= 12'd0;
            write_cnt <= 0;
            done_cnt  <= 0;
        end else begin
            if (buf_wr) begin
                shadow[line_buf.addr] <= {1'b1, line_buf.data};
                write_cnt <= write_cnt + 1;
            end
            if (done) done_cnt <= done_cnt + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic int tile_width(input logic [2:0] size);
        case (size)
            SIZE_8:  return 8;
            SIZE_16: return 16;
            default: return 32;
        endcase
    endfunction

    // expected pixel of buffer entry x at map column hpos + x
    function automatic logic [10:0] expect_pixel(input line_cfg_t c, input int x);
        int          w;
        int          r;
        int          p;
        int          s;
        logic [10:0] col;
        logic [10:0] vn;
        logic [11:0] index;
        logic [16:0] ca;
        logic [15:0] code;
        logic [15:0] attr;
        logic [19:0] pre;
        logic [19:0] ra;
        logic [31:0] word;
        logic [2:0]  k;
        logic [3:0]  colour;
        w   = tile_width(c.size);
        col = c.hpos[10:0] + 11'(x);
        vn  = c.vpos[10:0] + {2'd0, c.vrender};
        case (w)
            8:       index = {vn[8], col[8:3], vn[7:3]};
            16:      index = {vn[9:8], col[9:4], vn[7:4]};
            default: index = {vn[10:8], col[10:5], vn[7:5]};
        endcase
        ca   = {c.vram_base[9:1], 8'd0} + {4'd0, index, 1'b0};
        code = vram_word(ca);
        attr = vram_word(ca + 17'd1);
        r    = vn % w;
        if (attr[6]) r = w - 1 - r;   // vflip
        p = col % w;
        s = p / 8;
        if (attr[5]) s = w / 8 - 1 - s;   // hflip reverses the word slots
        k = 3'(p % 8);
        case (w)
            8:       pre = 20'(code) * 20'd8 + 20'(r);
            16:      pre = 20'(code) * 20'd16 + 20'(r);
            default: pre = 20'(code[13:0]) * 20'd64 + 20'(r) * 20'd2 + 20'(s / 2);
        endcase
        ra   = {(pre[19:16] & c.bank_mask) | c.bank_offset, pre[15:0]};
        word = rom_word(ra, (w == 8) ? 1'b0 : 1'(s % 2));
        if (attr[5]) begin
            colour = {word[24 + k], word[16 + k], word[8 + k], word[k]};
        end else begin
            colour = {word[31 - k], word[23 - k], word[15 - k], word[7 - k]};
        end
        return {attr[8:7], attr[4:0], colour};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks and run control

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run("stopping at the first mismatch");
        end
    endtask

    task automatic check_idle(input string when_txt);
        check_value({"vram_cs ", when_txt}, 32'(vram_cs), 32'd0);
        check_value({"rom_cs ", when_txt}, 32'(rom_cs), 32'd0);
        check_value({"buf_wr ", when_txt}, 32'(buf_wr), 32'd0);
        check_value({"done ", when_txt}, 32'(done), 32'd0);
    endtask

    task automatic add_row(input logic [2:0] size, input logic [15:0] hpos,
                           input logic [15:0] vpos, input logic [8:0] vrender,
                           input logic [15:0] base, input logic [3:0] offset,
                           input logic [3:0] mask, input logic [15:0] stop_at);
        line_row_t r;
        r.cfg.size        = size;
        r.cfg.hpos        = hpos;
        r.cfg.vpos        = vpos;
        r.cfg.vrender     = vrender;
        r.cfg.vram_base   = base;
        r.cfg.bank_offset = offset;
        r.cfg.bank_mask   = mask;
        r.stop_at         = stop_at;
        rows.push_back(r);
    endtask

    task automatic build_table;
        //      size     hpos      vpos      vrender  base      off   mask  stop
        add_row(SIZE_8,  16'h0013, 16'h0021, 9'd5,   16'h0200, 4'h0, 4'hf, 16'd0);
        add_row(SIZE_8,  16'h07fd, 16'h0100, 9'd200, 16'h0e04, 4'h3, 4'h5, 16'd0);
        add_row(SIZE_16, 16'h002b, 16'h0043, 9'd17,  16'h0300, 4'ha, 4'h3, 16'd0);
        add_row(SIZE_32, 16'h0131, 16'h07f0, 9'd300, 16'h0102, 4'h5, 4'hc, 16'd0);
        add_row(SIZE_16, 16'h0009, 16'h0011, 9'd99,  16'h0040, 4'h1, 4'hf, 16'd150);
        add_row(SIZE_32, 16'h0131, 16'h07f0, 9'd300, 16'h0102, 4'h5, 4'hc, 16'd0);
        add_row(SIZE_8,  16'h0013, 16'h0021, 9'd5,   16'h0200, 4'h0, 4'hf, 16'd0);
        add_row(SIZE_32, 16'h0000, 16'h0005, 9'd480, 16'hffff, 4'h0, 4'h0, 16'd0);
    endtask

    initial begin : watchdog
        #1;
        repeat (rows.size() * 4000 + 16) @(posedge clk);
        abort_run("timeout: the lines did not finish in the allowed cycles");
    end

    always @(posedge clk) begin
        if (u_dut.u_asserts.failures != 0) begin
            abort_run("a bound assertion on the DUT ports failed");
        end
    end

    initial begin : run
        line_row_t row;
        int        fine;
        int        n;
        rst   = 1'b1;
        cfg   = '0;
        start = 1'b0;
        stop  = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        repeat (20) begin
            @(posedge clk);
            check_idle("after reset");
        end
        check_value("write count after reset", 32'(write_cnt), 32'd0);

        for (int i = 0; i < rows.size(); i++) begin
            row  = rows[i];
            fine = row.cfg.hpos % tile_width(row.cfg.size);
            @(posedge clk);
            cfg   <= row.cfg;   // held until the next row
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            if (row.stop_at != 16'd0) begin
                repeat (row.stop_at) @(posedge clk);
                stop <= 1'b1;
                @(posedge clk);
                stop <= 1'b0;
                @(posedge clk);
                check_value("done after stop", 32'(done), 32'd1);
                check_value("buf_wr after stop", 32'(buf_wr), 32'd0);
                check_value("vram_cs after stop", 32'(vram_cs), 32'd0);
                check_value("rom_cs after stop", 32'(rom_cs), 32'd0);
                n = write_cnt;
                repeat (30) begin
                    @(posedge clk);
                    check_idle("after stop");
                end
                check_value("write count after stop", 32'(write_cnt), 32'(n));
                check_value("done pulses", 32'(done_cnt), 32'd1);
            end else begin
                do @(posedge clk); while (done !== 1'b1);
                repeat (4) begin
                    @(posedge clk);
                    check_idle("after done");
                end
                check_value("done pulses", 32'(done_cnt), 32'd1);
                check_value("write count", 32'(write_cnt), 32'(448 + fine));
                for (int x = 0; x <= 447; x++) begin
                    check_value($sformatf("line_buf[%0d]", x), 32'(shadow[x]),
                                32'({1'b1, expect_pixel(row.cfg, x)}));
                end
            end
        end

        if (u_dut.u_asserts.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tilemap_asserts.sv
`timescale 1ns/1ps

module tilemap_asserts (
    input logic                                clk,
    input logic                                rst,
    input tilemap_pkg::line_cfg_t              cfg,
    input logic                                vram_cs,
    input logic [tilemap_pkg::ROM_AW-1:0]      rom_addr,
    input logic                                rom_cs,
    input tilemap_pkg::buf_wr_t                line_buf,
    input logic                                buf_wr,
    input logic                                done
);
    import tilemap_pkg::*;

    int failures = 0;   // bumped by every failing assertion

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            failures++;
            $error("done stayed high for more than one cycle");
        end

    // nothing may still be moving once done is up
    done_quiet: assert property (@(posedge clk) disable iff (rst)
        done |-> !buf_wr && !vram_cs && !rom_cs)
        else begin
            failures++;
            $error("write or memory request active in the done cycle");
        end

    // top bits are (pre & mask) | offset
    bank_bits: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> ((rom_addr[19:16] & cfg.bank_offset) == cfg.bank_offset) &&
                   ((rom_addr[19:16] & ~(cfg.bank_mask | cfg.bank_offset)) == 4'd0))
        else begin
            failures++;
            $error("rom address bank bits outside mask and offset");
        end

    // only the fine scroll lead-in may land above the visible part
    write_range: assert property (@(posedge clk) disable iff (rst)
        buf_wr |-> (line_buf.addr <= LINE_LAST) || (line_buf.addr > 9'd480))
        else begin
            failures++;
            $error("line buffer write outside the line");
        end

endmodule

bind tilemap_engine tilemap_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .cfg     (cfg),
    .vram_cs (vram_cs),
    .rom_addr(rom_addr),
    .rom_cs  (rom_cs),
    .line_buf(line_buf),
    .buf_wr  (buf_wr),
    .done    (done)
);

//--- tilemap_engine.sv
`timescale 1ns/1ps

module tilemap_engine (
    input  logic                           clk,
    input  logic                           rst,
    input  tilemap_pkg::line_cfg_t         cfg,
    input  logic                           start,
    input  logic                           stop,
    output logic [tilemap_pkg::VRAM_AW-1:0] vram_addr,
    output logic                           vram_cs,
    input  logic [15:0]                    vram_data,
    input  logic                           vram_ok,
    output logic [tilemap_pkg::ROM_AW-1:0] rom_addr,
    output logic                           rom_half,
    output logic                           rom_cs,
    input  logic [31:0]                    rom_data,
    input  logic                           rom_ok,
    output tilemap_pkg::buf_wr_t           line_buf,
    output logic                           buf_wr,
    output logic                           done
);
    import tilemap_pkg::*;

    scan_pos_t  pos;
    logic [4:0] fine;
    logic       go;
    logic       busy;
    logic       push;
    pix_word_t  push_data;
    logic       full;
    logic       pop;
    logic       valid;
    pix_word_t  head;
    logic       line_end;

    line_setup u_setup (
        .clk  (clk),
        .rst  (rst),
        .cfg  (cfg),
        .start(start),
        .stop (stop),
        .busy (busy),
        .pos  (pos),
        .fine (fine),
        .go   (go)
    );

    tile_fetcher u_fetcher (
        .clk      (clk),
        .rst      (rst),
        .pos      (pos),
        .go       (go),
        .stop     (stop),
        .line_end (line_end),
        .full     (full),
        .vram_addr(vram_addr),
        .vram_cs  (vram_cs),
        .vram_data(vram_data),
        .vram_ok  (vram_ok),
        .rom_addr (rom_addr),
        .rom_half (rom_half),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .push     (push),
        .push_data(push_data)
    );

    pixel_queue u_queue (
        .clk      (clk),
        .rst      (rst),
        .flush    (line_end || stop),   // leftover words are dropped
        .push     (push),
        .push_data(push_data),
        .full     (full),
        .pop      (pop),
        .valid    (valid),
        .head     (head)
    );

    line_writer u_writer (
        .clk     (clk),
        .rst     (rst),
        .go      (go),
        .fine    (fine),
        .stop    (stop),
        .valid   (valid),
        .head    (head),
        .pop     (pop),
        .line_buf(line_buf),
        .buf_wr  (buf_wr),
        .line_end(line_end),
        .busy    (busy),
        .done    (done)
    );

endmodule

//--- line_writer.sv
`timescale 1ns/1ps

module line_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   go,
    input  logic [4:0]             fine,
    input  logic                   stop,
    input  logic                   valid,
    input  tilemap_pkg::pix_word_t head,
    output logic                   pop,
    output tilemap_pkg::buf_wr_t   line_buf,
    output logic                   buf_wr,
    output logic                   line_end,
    output logic                   busy,
    output logic                   done
);
    import tilemap_pkg::*;

    logic [2:0] k;        // pixel within the head word
    logic       draw;
    logic [3:0] colour;

    // the write of the last entry is on the port this cycle
    assign line_end = buf_wr && (line_buf.addr == LINE_LAST);
    assign draw     = busy && valid && !line_end && !stop;
    assign pop      = draw && (k == 3'd7);

    ////////////////////////////////////////////////////////////////////////////
    // planar to packed pixel

    always_comb begin
        if (head.attr.hflip) begin
            colour = {head.word[24 + k], head.word[16 + k],
                      head.word[8 + k], head.word[k]};
        end else begin
            colour = {head.word[31 - k], head.word[23 - k],
                      head.word[15 - k], head.word[7 - k]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // line control

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            buf_wr <= 1'b0;
            done   <= 1'b0;
            k      <= 3'd0;
        end else begin
            done   <= line_end || stop;
            buf_wr <= draw;   // low while the queue runs dry
            if (stop || line_end) begin
                busy <= 1'b0;
            end else if (go) begin
                busy <= 1'b1;
                k    <= 3'd0;
            end
            if (draw) k <= k + 3'd1;
        end
    end

    // address is pre-incremented, first pixel lands at -fine
    always_ff @(posedge clk) begin
        if (go) begin
            line_buf.addr <= 9'h1ff - {4'd0, fine};
        end else if (draw) begin
            line_buf.addr <= line_buf.addr + 1'b1;
        end
        if (draw) line_buf.data <= {head.attr.group, head.attr.pal, colour};
    end

endmodule

//--- pixel_queue.sv
`timescale 1ns/1ps

module pixel_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   push,
    input  tilemap_pkg::pix_word_t push_data,
    output logic                   full,
    input  logic                   pop,
    output logic                   valid,
    output tilemap_pkg::pix_word_t head
);
    import tilemap_pkg::*;

    pix_word_t  mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       do_push;
    logic       do_pop;

    assign full    = (count == 2'd2);
    assign valid   = (count != 2'd0);
    assign head    = mem[rd_ptr];
    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else if (flush) begin   // end of line or abort
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (do_push) wr_ptr <= ~wr_ptr;
            if (do_pop) rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, do_push} - {1'b0, do_pop};
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

//--- tile_fetcher.sv
`timescale 1ns/1ps

module tile_fetcher (
    input  logic                           clk,
    input  logic                           rst,
    input  tilemap_pkg::scan_pos_t         pos,
    input  logic                           go,
    input  logic                           stop,
    input  logic                           line_end,
    input  logic                           full,
    output logic [tilemap_pkg::VRAM_AW-1:0] vram_addr,
    output logic                           vram_cs,
    input  logic [15:0]                    vram_data,
    input  logic                           vram_ok,
    output logic [tilemap_pkg::ROM_AW-1:0] rom_addr,
    output logic                           rom_half,
    output logic                           rom_cs,
    input  logic [31:0]                    rom_data,
    input  logic                           rom_ok,
    output logic                           push,
    output tilemap_pkg::pix_word_t         push_data
);
    import tilemap_pkg::*;

    typedef enum logic [2:0] {
        s_idle, s_code_req, s_code, s_attr_req, s_attr, s_rom_req, s_rom
    } state_t;

    state_t             st;
    logic [10:0]        hn;          // column of the tile being fetched
    logic [10:0]        hn_sel;
    logic [15:0]        code;
    tile_attr_t         attr;
    logic [1:0]         j;           // word in display order
    logic [1:0]         last_j;
    logic [1:0]         slot;        // word in rom order
    logic [10:0]        step;
    logic [11:0]        index;
    logic [4:0]         row;
    logic [ROM_AW-1:0]  pre_addr;
    logic [ROM_AW-1:0]  rom_next;
    logic [VRAM_AW-1:0] code_addr;

    ////////////////////////////////////////////////////////////////////////////
    // address forming

    always_comb begin
        hn_sel = (st == s_idle) ? pos.hn : hn;   // go uses the setup value
        row    = pos.vn[4:0] ^ {5{attr.vflip}};
        case (pos.size)
            SIZE_8: begin
                index    = {pos.vn[8], hn_sel[8:3], pos.vn[7:3]};
                step     = 11'd8;
                last_j   = 2'd0;
                pre_addr = {1'b0, code, row[2:0]};
            end
            SIZE_16: begin
                index    = {pos.vn[9:8], hn_sel[9:4], pos.vn[7:4]};
                step     = 11'd16;
                last_j   = 2'd1;
                pre_addr = {code, row[3:0]};
            end
            default: begin
                index    = {pos.vn[10:8], hn_sel[10:5], pos.vn[7:5]};
                step     = 11'd32;
                last_j   = 2'd3;
                pre_addr = {code[13:0], row, slot[1]};
            end
        endcase
        // W/8-1-j is the same as j xor all ones, kept inside the word count
        slot      = (j ^ {2{attr.hflip}}) & last_j;
        code_addr = {pos.vram_base[9:1], 8'd0} + {4'd0, index, 1'b0};
        rom_next  = {(pre_addr[19:16] & pos.bank_mask) | pos.bank_offset,
                     pre_addr[15:0]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // fetch sequence

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= s_idle;
            vram_cs   <= 1'b0;
            rom_cs    <= 1'b0;
            vram_addr <= '0;
            rom_addr  <= '0;
            rom_half  <= 1'b0;
            hn        <= '0;
            code      <= '0;
            attr      <= '0;
            j         <= '0;
        end else if (stop || line_end) begin
            st      <= s_idle;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
        end else begin
            case (st)
                s_idle: if (go) begin
                    hn        <= pos.hn;
                    vram_addr <= code_addr;
                    vram_cs   <= 1'b1;
                    st        <= s_code;
                end
                s_code_req: begin
                    vram_addr <= code_addr;
                    vram_cs   <= 1'b1;
                    st        <= s_code;
                end
                s_code: if (vram_ok) begin
                    code      <= vram_data;
                    vram_cs   <= 1'b0;
                    vram_addr <= vram_addr + 1'b1;   // attribute follows the code
                    st        <= s_attr_req;
                end
                s_attr_req: begin
                    vram_cs <= 1'b1;
                    st      <= s_attr;
                end
                s_attr: if (vram_ok) begin
                    attr    <= tile_attr_t'(vram_data[8:0]);
                    vram_cs <= 1'b0;
                    j       <= 2'd0;
                    st      <= s_rom_req;
                end
                s_rom_req: if (!full) begin   // back-pressure from the queue
                    rom_addr <= rom_next;
                    rom_half <= slot[0];
                    rom_cs   <= 1'b1;
                    st       <= s_rom;
                end
                s_rom: if (rom_ok) begin
                    rom_cs <= 1'b0;
                    if (j == last_j) begin
                        hn <= hn + step;
                        st <= s_code_req;
                    end else begin
                        j  <= j + 2'd1;
                        st <= s_rom_req;
                    end
                end
                default: st <= s_idle;
            endcase
        end
    end

    // word goes straight into the queue in its ok cycle
    assign push = (st == s_rom) && rom_ok;

    always_comb begin
        push_data.word = rom_data;
        push_data.attr = attr;
    end

endmodule

//--- line_setup.sv
`timescale 1ns/1ps

module line_setup (
    input  logic                   clk,
    input  logic                   rst,
    input  tilemap_pkg::line_cfg_t cfg,
    input  logic                   start,
    input  logic                   stop,
    input  logic                   busy,
    output tilemap_pkg::scan_pos_t pos,
    output logic [4:0]             fine,
    output logic                   go
);
    import tilemap_pkg::*;

    line_cfg_t   cfg_q;
    logic [10:0] vn;
    logic [10:0] hn;
    logic        take;

    // a new line is only accepted while nothing is in flight
    assign take = start && !busy && !go;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go <= 1'b0;
        end else begin
            go <= take && !stop;   // stop drops a pending go
        end
    end

    always_ff @(posedge clk) begin
        if (take) cfg_q <= cfg;
    end

    always_comb begin
        vn = cfg_q.vpos[10:0] + {2'd0, cfg_q.vrender};
        case (cfg_q.size)
            SIZE_8: begin
                hn   = {cfg_q.hpos[10:3], 3'd0};
                fine = {2'd0, cfg_q.hpos[2:0]};
            end
            SIZE_16: begin
                hn   = {cfg_q.hpos[10:4], 4'd0};
                fine = {1'd0, cfg_q.hpos[3:0]};
            end
            default: begin   // 32x32
                hn   = {cfg_q.hpos[10:5], 5'd0};
                fine = cfg_q.hpos[4:0];
            end
        endcase
    end

    always_comb begin
        pos.size        = cfg_q.size;
        pos.vn          = vn;
        pos.hn          = hn;
        pos.vram_base   = cfg_q.vram_base;
        pos.bank_offset = cfg_q.bank_offset;
        pos.bank_mask   = cfg_q.bank_mask;
    end

endmodule

//--- tilemap_pkg.sv
package tilemap_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes and widths

    // one-hot tile size codes
    localparam logic [2:0] SIZE_8  = 3'b001;
    localparam logic [2:0] SIZE_16 = 3'b010;
    localparam logic [2:0] SIZE_32 = 3'b100;

    localparam int BUF_AW  = 9;    // line buffer address
    localparam int VRAM_AW = 17;   // vram word address
    localparam int ROM_AW  = 20;   // gfx rom word address

    // last visible buffer entry of a line
    localparam logic [BUF_AW-1:0] LINE_LAST = 9'd447;

    ////////////////////////////////////////////////////////////////////////////
    // shared records

    // layer settings as given with start
    typedef struct packed {
        logic [2:0]  size;         // one-hot
        logic [15:0] vram_base;
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [8:0]  vrender;      // line being drawn
        logic [3:0]  bank_offset;
        logic [3:0]  bank_mask;
    } line_cfg_t;

    // scan position handed to the fetcher
    typedef struct packed {
        logic [2:0]  size;
        logic [10:0] vn;           // map row
        logic [10:0] hn;           // first column, tile aligned
        logic [15:0] vram_base;
        logic [3:0]  bank_offset;
        logic [3:0]  bank_mask;
    } scan_pos_t;

    // same bit order as attribute word bits 8:0
    typedef struct packed {
        logic [1:0] group;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } tile_attr_t;

    // one planar rom word plus the attribute of its tile
    typedef struct packed {
        logic [31:0] word;
        tile_attr_t  attr;
    } pix_word_t;

    // line buffer write, data is {group, pal, colour}
    typedef struct packed {
        logic [BUF_AW-1:0] addr;
        logic [10:0]       data;
    } buf_wr_t;

endpackage
